// ==== pwrmgr_config.svh ====
// widths and encodings for the power manager; counts are fixed here, not per instance
`ifndef PWRMGR_CONFIG_SVH
`define PWRMGR_CONFIG_SVH

//////////////////////////////
// request widths
//////////////////////////////

// peripheral wakeup lines
`define PWR_NUM_WKUPS 4

// peripheral reset request lines
`define PWR_NUM_RST_REQS 2

//////////////////////////////
// escalation and sw reset
//////////////////////////////

// cycles without a heartbeat before a timeout
`define PWR_ESC_TIMEOUT_CNT 64

// only multi-bit true value requests a sw reset
`define PWR_MUBI4_TRUE 4'h6

`endif

// ==== pwrmgr_pkg.sv ====
// shared types for the power manager; widths come from the config header
`include "pwrmgr_config.svh"

package pwrmgr_pkg;

  //////////////////////////////
  // request vectors
  //////////////////////////////

  // one bit per wakeup line
  typedef logic [`PWR_NUM_WKUPS-1:0] pwr_wkup_vec_t;

  // reset sources, peripheral lines in the lsbs
  typedef struct packed {
    logic                           sw;
    logic                           ndm;
    logic                           esc;
    logic [`PWR_NUM_RST_REQS-1:0]   periph;
  } pwr_rst_vec_t;

  //////////////////////////////
  // sw config and status
  //////////////////////////////

  typedef struct packed {
    logic                         low_power_hint;
    pwr_wkup_vec_t                wakeup_en;
    logic [`PWR_NUM_RST_REQS-1:0] reset_en;
    logic                         intr_en;
  } pwr_cfg_t;

  // requests toward the reset manager
  typedef struct packed {
    logic rst_sys_req;
    logic rst_lc_req;
  } pwr_rst_req_t;

  typedef struct packed {
    logic          abort;
    logic          fall_through;
    pwr_wkup_vec_t reasons;
  } pwr_wake_info_t;

  // fast fsm encoding
  typedef enum logic [2:0] {
    PowerUp      = 3'd0,
    Active       = 3'd1,
    LowPowerPrep = 3'd2,
    LowPower     = 3'd3,
    Wake         = 3'd4,
    ResetPrep    = 3'd5,
    ResetWait    = 3'd6
  } pwr_fsm_state_e;

endpackage

// ==== pwrmgr_req_capture.sv ====
// requests must be levels held for at least 2 cycles; output lags input by exactly 2 cycles
`timescale 1ns/1ps

module pwrmgr_req_capture #(
  parameter type req_t = logic
) (
  input  logic clk_i,
  input  logic rst_caliptra_ss_lc_n,
  input  req_t req_i,
  input  req_t mask_i,
  output req_t masked_o
);

  //////////////////////////////
  // two flop synchronizer
  //////////////////////////////

  // first stage may go metastable
  req_t sync_q1;
  // second stage is safe to use
  req_t sync_q2;

  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= req_i;
      sync_q2 <= sync_q1;
    end
  end

  //////////////////////////////
  // enable mask
  //////////////////////////////

  // mask is applied after the sync, so
  // a new enable takes effect at once
  assign masked_o = req_t'(sync_q2 & mask_i);

endmodule

// ==== pwrmgr_esc_monitor.sv ====
// escalation and timeout latch until reset; heartbeat is checked only while clocks are enabled
`timescale 1ns/1ps
`include "pwrmgr_config.svh"

module pwrmgr_esc_monitor (
  input  logic clk_i,
  input  logic rst_caliptra_ss_lc_n,
  input  logic esc_req_i,
  input  logic esc_ping_i,
  input  logic chk_en_i,
  output logic esc_rst_o,
  output logic esc_timeout_o
);

  localparam int CntW = $clog2(`PWR_ESC_TIMEOUT_CNT + 1);

  logic            esc_q;
  logic            timeout_q;
  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      esc_q     <= 1'b0;
      timeout_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      // sticky once seen
      if (esc_req_i) begin
        esc_q <= 1'b1;
      end
      // heartbeat restarts the count, gated clocks stop the check
      if (esc_ping_i || !chk_en_i) begin
        cnt_q <= '0;
      end else if (cnt_q != CntW'(`PWR_ESC_TIMEOUT_CNT)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // count saturated, heartbeat lost
      if (cnt_q == CntW'(`PWR_ESC_TIMEOUT_CNT)) begin
        timeout_q <= 1'b1;
      end
    end
  end

  assign esc_timeout_o = timeout_q;
  assign esc_rst_o     = esc_q | timeout_q;

  // escalation reset holds until power-on reset
  esc_rst_sticky_a: assert property (
    @(posedge clk_i) disable iff (!rst_caliptra_ss_lc_n)
    esc_rst_o |=> esc_rst_o
  );

endmodule

// ==== pwrmgr_fsm.sv ====
// clock and reset managers must answer with level handshakes; no timeout on either wait
`timescale 1ns/1ps

module pwrmgr_fsm (
  input  logic                        clk_i,
  input  logic                        rst_caliptra_ss_lc_n,
  input  logic                        low_power_entry_i,
  input  logic                        core_sleeping_i,
  input  pwrmgr_pkg::pwr_wkup_vec_t   wakeups_i,
  input  pwrmgr_pkg::pwr_rst_vec_t    reset_reqs_i,
  input  logic                        clk_status_i,
  input  logic                        rst_ack_i,
  output logic                        clk_en_o,
  output pwrmgr_pkg::pwr_rst_req_t    pwr_rst_o,
  output logic                        low_power_o,
  output logic                        wkup_o,
  output logic                        fall_through_o,
  output logic                        abort_o,
  output logic                        clr_hint_o,
  output pwrmgr_pkg::pwr_rst_vec_t    reset_cause_o
);

  pwrmgr_pkg::pwr_fsm_state_e state_q, state_d;
  pwrmgr_pkg::pwr_rst_req_t   rst_req_q, rst_req_d;
  pwrmgr_pkg::pwr_rst_vec_t   cause_q, cause_d;
  logic clk_en_q, clk_en_d;
  logic low_power_q, low_power_d;
  // set when the next entry to active is a real wakeup
  logic wkup_pend_q, wkup_pend_d;
  logic wkup_q, wkup_d;
  logic fall_q, fall_d;
  logic abort_q, abort_d;
  logic clr_hint_q, clr_hint_d;
  logic any_wkup;
  logic any_rst;

  assign any_wkup = |wakeups_i;
  assign any_rst  = |reset_reqs_i;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d     = state_q;
    rst_req_d   = rst_req_q;
    cause_d     = cause_q;
    clk_en_d    = clk_en_q;
    low_power_d = low_power_q;
    wkup_pend_d = wkup_pend_q;
    wkup_d      = 1'b0;
    fall_d      = 1'b0;
    abort_d     = 1'b0;
    clr_hint_d  = 1'b0;

    unique case (state_q)
      pwrmgr_pkg::PowerUp: begin
        clk_en_d = 1'b1;
        // wait for clocks to come back
        if (clk_en_q && clk_status_i) begin
          state_d     = pwrmgr_pkg::Active;
          wkup_d      = wkup_pend_q;
          wkup_pend_d = 1'b0;
        end
      end
      pwrmgr_pkg::Active: begin
        if (low_power_entry_i) begin
          state_d    = pwrmgr_pkg::LowPowerPrep;
          clk_en_d   = 1'b0;
          clr_hint_d = 1'b1;
        end
      end
      pwrmgr_pkg::LowPowerPrep: begin
        // wakeup already pending, fall through
        if (any_wkup) begin
          state_d  = pwrmgr_pkg::Wake;
          clk_en_d = 1'b1;
          fall_d   = 1'b1;
        // core woke up on its own
        end else if (!core_sleeping_i) begin
          state_d  = pwrmgr_pkg::Wake;
          clk_en_d = 1'b1;
          abort_d  = 1'b1;
        end else if (!clk_status_i) begin
          state_d     = pwrmgr_pkg::LowPower;
          low_power_d = 1'b1;
        end
      end
      pwrmgr_pkg::LowPower: begin
        if (any_wkup) begin
          state_d     = pwrmgr_pkg::Wake;
          clk_en_d    = 1'b1;
          low_power_d = 1'b0;
          wkup_pend_d = 1'b1;
        end
      end
      pwrmgr_pkg::Wake: begin
        if (clk_status_i) begin
          state_d     = pwrmgr_pkg::Active;
          wkup_d      = wkup_pend_q;
          wkup_pend_d = 1'b0;
        end
      end
      pwrmgr_pkg::ResetPrep: begin
        // requests drop once acked
        if (rst_ack_i) begin
          state_d   = pwrmgr_pkg::ResetWait;
          rst_req_d = '0;
        end
      end
      pwrmgr_pkg::ResetWait: begin
        if (!rst_ack_i) begin
          state_d     = pwrmgr_pkg::PowerUp;
          wkup_pend_d = 1'b1;
        end
      end
      default: begin
        state_d = pwrmgr_pkg::PowerUp;
      end
    endcase

    // reset requests win from any state outside the reset handshake
    if (any_rst && state_q != pwrmgr_pkg::ResetPrep &&
        state_q != pwrmgr_pkg::ResetWait) begin
      state_d               = pwrmgr_pkg::ResetPrep;
      cause_d               = reset_reqs_i;
      rst_req_d.rst_sys_req = 1'b1;
      rst_req_d.rst_lc_req  = reset_reqs_i.esc;
      low_power_d           = 1'b0;
      clk_en_d              = clk_en_q;
      wkup_d                = 1'b0;
      fall_d                = 1'b0;
      abort_d               = 1'b0;
      clr_hint_d            = 1'b0;
    end
  end

  //////////////////////////////
  // state and outputs
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      state_q     <= pwrmgr_pkg::PowerUp;
      rst_req_q   <= '0;
      cause_q     <= '0;
      clk_en_q    <= 1'b1;
      low_power_q <= 1'b0;
      wkup_pend_q <= 1'b0;
      wkup_q      <= 1'b0;
      fall_q      <= 1'b0;
      abort_q     <= 1'b0;
      clr_hint_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      rst_req_q   <= rst_req_d;
      cause_q     <= cause_d;
      clk_en_q    <= clk_en_d;
      low_power_q <= low_power_d;
      wkup_pend_q <= wkup_pend_d;
      wkup_q      <= wkup_d;
      fall_q      <= fall_d;
      abort_q     <= abort_d;
      clr_hint_q  <= clr_hint_d;
    end
  end

  assign clk_en_o       = clk_en_q;
  assign pwr_rst_o      = rst_req_q;
  assign low_power_o    = low_power_q;
  assign wkup_o         = wkup_q;
  assign fall_through_o = fall_q;
  assign abort_o        = abort_q;
  assign clr_hint_o     = clr_hint_q;
  assign reset_cause_o  = cause_q;

  // lc reset never goes out alone
  lc_with_sys_a: assert property (
    @(posedge clk_i) disable iff (!rst_caliptra_ss_lc_n)
    pwr_rst_o.rst_lc_req |-> pwr_rst_o.rst_sys_req
  );

endmodule

// ==== pwrmgr_wake_info.sv ====
// record is sticky until cleared; reasons are only captured while in low power
`timescale 1ns/1ps

module pwrmgr_wake_info (
  input  logic                        clk_i,
  input  logic                        rst_caliptra_ss_lc_n,
  input  logic                        clr_i,
  input  logic                        capture_i,
  input  pwrmgr_pkg::pwr_wkup_vec_t   wakeups_i,
  input  logic                        fall_through_i,
  input  logic                        abort_i,
  output pwrmgr_pkg::pwr_wake_info_t  info_o
);

  pwrmgr_pkg::pwr_wake_info_t info_q;

  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      info_q <= '0;
    end else if (clr_i) begin
      // clear beats any set in the same cycle
      info_q <= '0;
    end else begin
      // accumulate masked wakeups seen in low power
      if (capture_i) begin
        info_q.reasons <= info_q.reasons | wakeups_i;
      end
      if (fall_through_i) begin
        info_q.fall_through <= 1'b1;
      end
      if (abort_i) begin
        info_q.abort <= 1'b1;
      end
    end
  end

  assign info_o = info_q;

endmodule

// ==== pwrmgr_cfg_regs.sv ====
// writes are dropped without response while locked; lock reopens only on wakeup, fall-through or abort
`timescale 1ns/1ps

module pwrmgr_cfg_regs (
  input  logic                  clk_i,
  input  logic                  rst_caliptra_ss_lc_n,
  input  logic                  cfg_wr_i,
  input  pwrmgr_pkg::pwr_cfg_t  cfg_i,
  input  logic                  clr_hint_i,
  input  logic                  wkup_i,
  input  logic                  clr_lock_i,
  input  logic                  intr_clr_i,
  output pwrmgr_pkg::pwr_cfg_t  cfg_o,
  output logic                  cfg_regwen_o,
  output logic                  intr_wakeup_o
);

  pwrmgr_pkg::pwr_cfg_t cfg_q;
  logic regwen_q;
  logic intr_state_q;

  //////////////////////////////
  // config register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      cfg_q <= '0;
    end else begin
      if (cfg_wr_i && regwen_q) begin
        cfg_q <= cfg_i;
      end
      // fsm wipes the hint on low power entry
      if (clr_hint_i) begin
        cfg_q.low_power_hint <= 1'b0;
      end
    end
  end

  // lock while a low power entry is pending
  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      regwen_q <= 1'b1;
    end else if (!regwen_q && (wkup_i || clr_lock_i)) begin
      regwen_q <= 1'b1;
    end else if (cfg_q.low_power_hint) begin
      regwen_q <= 1'b0;
    end
  end

  //////////////////////////////
  // wakeup interrupt
  //////////////////////////////

  // new event wins over a clear
  always_ff @(posedge clk_i or negedge rst_caliptra_ss_lc_n) begin
    if (!rst_caliptra_ss_lc_n) begin
      intr_state_q <= 1'b0;
    end else if (wkup_i) begin
      intr_state_q <= 1'b1;
    end else if (intr_clr_i) begin
      intr_state_q <= 1'b0;
    end
  end

  assign cfg_o         = cfg_q;
  assign cfg_regwen_o  = regwen_q;
  assign intr_wakeup_o = intr_state_q & cfg_q.intr_en;

  // locked write leaves the config alone
  locked_write_a: assert property (
    @(posedge clk_i) disable iff (!rst_caliptra_ss_lc_n)
    (cfg_wr_i && !cfg_regwen_o && !clr_hint_i) |=> (cfg_o == $past(cfg_o))
  );

endmodule

// ==== pwrmgr_top.sv ====
// single clock domain; all request inputs are levels held until their effect is seen
`timescale 1ns/1ps
`include "pwrmgr_config.svh"

module pwrmgr_top (
  input  logic                          clk_i,
  input  logic                          rst_caliptra_ss_lc_n,
  input  logic                          cfg_wr_i,
  input  pwrmgr_pkg::pwr_cfg_t          cfg_i,
  input  logic                          intr_clr_i,
  input  logic                          wake_info_clr_i,
  input  pwrmgr_pkg::pwr_wkup_vec_t     wakeups_i,
  input  logic [`PWR_NUM_RST_REQS-1:0]  rstreqs_i,
  input  logic [3:0]                    sw_rst_req_i,
  input  logic                          ndmreset_req_i,
  input  logic                          esc_req_i,
  input  logic                          esc_ping_i,
  input  logic                          core_sleeping_i,
  input  logic                          clk_status_i,
  input  logic                          rst_ack_i,
  output logic                          clk_en_o,
  output pwrmgr_pkg::pwr_rst_req_t      pwr_rst_o,
  output logic                          low_power_o,
  output logic                          cfg_regwen_o,
  output logic                          intr_wakeup_o,
  output logic                          esc_timeout_o,
  output pwrmgr_pkg::pwr_wake_info_t    wake_info_o,
  output pwrmgr_pkg::pwr_rst_vec_t      reset_cause_o
);

  pwrmgr_pkg::pwr_cfg_t       cfg;
  pwrmgr_pkg::pwr_wkup_vec_t  wkup_masked;
  pwrmgr_pkg::pwr_rst_vec_t   rst_raw;
  pwrmgr_pkg::pwr_rst_vec_t   rst_mask;
  pwrmgr_pkg::pwr_rst_vec_t   rst_masked;
  logic esc_rst;
  logic wkup;
  logic fall_through;
  logic abort;
  logic clr_hint;

  //////////////////////////////
  // raw reset vector
  //////////////////////////////

  assign rst_raw.periph = rstreqs_i;
  assign rst_raw.esc    = esc_rst;
  assign rst_raw.ndm    = ndmreset_req_i;
  // strict compare, any other value is no request
  assign rst_raw.sw     = (sw_rst_req_i == `PWR_MUBI4_TRUE);

  // only peripheral lines are sw maskable
  assign rst_mask.periph = cfg.reset_en;
  assign rst_mask.esc    = 1'b1;
  assign rst_mask.ndm    = 1'b1;
  assign rst_mask.sw     = 1'b1;

  //////////////////////////////
  // request capture
  //////////////////////////////

  pwrmgr_req_capture #(.req_t(pwrmgr_pkg::pwr_wkup_vec_t)) u_wkup_capture (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .req_i    (wakeups_i),
    .mask_i   (cfg.wakeup_en),
    .masked_o (wkup_masked)
  );

  pwrmgr_req_capture #(.req_t(pwrmgr_pkg::pwr_rst_vec_t)) u_rst_capture (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .req_i    (rst_raw),
    .mask_i   (rst_mask),
    .masked_o (rst_masked)
  );

  // heartbeat only expected while clocks run
  pwrmgr_esc_monitor u_esc_monitor (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .esc_req_i,
    .esc_ping_i,
    .chk_en_i      (clk_en_o),
    .esc_rst_o     (esc_rst),
    .esc_timeout_o
  );

  //////////////////////////////
  // fast fsm
  //////////////////////////////

  pwrmgr_fsm u_fsm (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .low_power_entry_i (core_sleeping_i & cfg.low_power_hint),
    .core_sleeping_i,
    .wakeups_i         (wkup_masked),
    .reset_reqs_i      (rst_masked),
    .clk_status_i,
    .rst_ack_i,
    .clk_en_o,
    .pwr_rst_o,
    .low_power_o,
    .wkup_o            (wkup),
    .fall_through_o    (fall_through),
    .abort_o           (abort),
    .clr_hint_o        (clr_hint),
    .reset_cause_o
  );

  pwrmgr_wake_info u_wake_info (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .clr_i          (wake_info_clr_i),
    .capture_i      (low_power_o),
    .wakeups_i      (wkup_masked),
    .fall_through_i (fall_through),
    .abort_i        (abort),
    .info_o         (wake_info_o)
  );

  // fall-through and abort also reopen the lock
  pwrmgr_cfg_regs u_cfg_regs (
    .clk_i,
    .rst_caliptra_ss_lc_n,
    .cfg_wr_i,
    .cfg_i,
    .clr_hint_i    (clr_hint),
    .wkup_i        (wkup),
    .clr_lock_i    (fall_through | abort),
    .intr_clr_i,
    .cfg_o         (cfg),
    .cfg_regwen_o,
    .intr_wakeup_o
  );

endmodule

// ==== tb_pwrmgr.sv ====
// drives inputs on the falling edge; clock and reset manager responders answer after 1 to 4 cycles
`timescale 1ns/1ps
`include "pwrmgr_config.svh"

module tb_pwrmgr;

  // select codes for the wait loop
  localparam int sig_low_power   = 0;
  localparam int sig_clk_en      = 1;
  localparam int sig_sys_req     = 2;
  localparam int sig_lc_req      = 3;
  localparam int sig_regwen      = 4;
  localparam int sig_intr        = 5;
  localparam int sig_esc_timeout = 6;

  logic                         clk_i;
  logic                         rst_caliptra_ss_lc_n;
  logic                         cfg_wr_i;
  pwrmgr_pkg::pwr_cfg_t         cfg_i;
  logic                         intr_clr_i;
  logic                         wake_info_clr_i;
  pwrmgr_pkg::pwr_wkup_vec_t    wakeups_i;
  logic [`PWR_NUM_RST_REQS-1:0] rstreqs_i;
  logic [3:0]                   sw_rst_req_i;
  logic                         ndmreset_req_i;
  logic                         esc_req_i;
  logic                         esc_ping_i;
  logic                         core_sleeping_i;
  logic                         clk_status_i;
  logic                         rst_ack_i;
  logic                         clk_en_o;
  pwrmgr_pkg::pwr_rst_req_t     pwr_rst_o;
  logic                         low_power_o;
  logic                         cfg_regwen_o;
  logic                         intr_wakeup_o;
  logic                         esc_timeout_o;
  pwrmgr_pkg::pwr_wake_info_t   wake_info_o;
  pwrmgr_pkg::pwr_rst_vec_t     reset_cause_o;

  // model state shared with the reset monitor
  string                    test_name;
  pwrmgr_pkg::pwr_cfg_t     cfg_model;
  pwrmgr_pkg::pwr_rst_req_t exp_rst;
  pwrmgr_pkg::pwr_rst_vec_t exp_cause;
  logic                     rst_seen;
  logic                     ping_en;
  int                       clk_delay;
  int                       ack_delay;
  int                       ping_cnt;

  pwrmgr_top pwrmgr_top_inst (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  //////////////////////////////
  // checks and reference
  //////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s %s expected %0b actual %0b", test_name, what, exp, act));
    end
  endtask

  task automatic check_rst(input string what, input pwrmgr_pkg::pwr_rst_req_t exp,
                           input pwrmgr_pkg::pwr_rst_req_t act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_cause(input string what, input pwrmgr_pkg::pwr_rst_vec_t exp,
                             input pwrmgr_pkg::pwr_rst_vec_t act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_wake_info(input string what, input pwrmgr_pkg::pwr_wake_info_t exp,
                                 input pwrmgr_pkg::pwr_wake_info_t act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  // masking rules: periph by reset_en, esc/ndm always, sw only on the true code
  function automatic pwrmgr_pkg::pwr_rst_req_t expected_reset(
    input logic [`PWR_NUM_RST_REQS-1:0] periph,
    input logic                         ndm,
    input logic [3:0]                   sw,
    input logic                         esc,
    input pwrmgr_pkg::pwr_cfg_t         cfg,
    output pwrmgr_pkg::pwr_rst_vec_t    cause
  );
    pwrmgr_pkg::pwr_rst_req_t req;
    cause.periph    = periph & cfg.reset_en;
    cause.esc       = esc;
    cause.ndm       = ndm;
    cause.sw        = (sw == `PWR_MUBI4_TRUE);
    req.rst_sys_req = |cause;
    // lc reset only for escalation
    req.rst_lc_req  = cause.esc;
    return req;
  endfunction

  // reasons only from enabled lines seen in low power
  function automatic pwrmgr_pkg::pwr_wake_info_t expected_wake(
    input pwrmgr_pkg::pwr_wkup_vec_t lines,
    input pwrmgr_pkg::pwr_wkup_vec_t en,
    input logic                      fall,
    input logic                      abort
  );
    pwrmgr_pkg::pwr_wake_info_t info;
    info.reasons      = lines & en;
    info.fall_through = fall;
    info.abort        = abort;
    return info;
  endfunction

  function automatic pwrmgr_pkg::pwr_cfg_t make_cfg(input logic hint,
      input pwrmgr_pkg::pwr_wkup_vec_t en, input logic [`PWR_NUM_RST_REQS-1:0] rst_en,
      input logic intr_en);
    pwrmgr_pkg::pwr_cfg_t c;
    c.low_power_hint = hint;
    c.wakeup_en      = en;
    c.reset_en       = rst_en;
    c.intr_en        = intr_en;
    return c;
  endfunction

  function automatic int lowest_bit(input pwrmgr_pkg::pwr_wkup_vec_t v, input logic val);
    int idx;
    idx = 0;
    for (int i = `PWR_NUM_WKUPS - 1; i >= 0; i--) begin
      if (v[i] == val) idx = i;
    end
    return idx;
  endfunction

  function automatic logic watched_bit(input int sel);
    case (sel)
      sig_low_power: return low_power_o;
      sig_clk_en:    return clk_en_o;
      sig_sys_req:   return pwr_rst_o.rst_sys_req;
      sig_lc_req:    return pwr_rst_o.rst_lc_req;
      sig_regwen:    return cfg_regwen_o;
      sig_intr:      return intr_wakeup_o;
      default:       return esc_timeout_o;
    endcase
  endfunction

  // polls once per falling edge, gives up after limit cycles
  task automatic wait_bit(input string what, input int sel, input logic val,
                          input int limit, output int cycles);
    cycles = 0;
    while (watched_bit(sel) !== val && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (watched_bit(sel) !== val) begin
      fail_stop($sformatf("timeout in %s while waiting for %s", test_name, what));
    end
  endtask

  //////////////////////////////
  // manager responders
  //////////////////////////////

  // clock status trails the enable
  initial begin
    clk_status_i = 1'b0;
    clk_delay    = 0;
    forever begin
      @(negedge clk_i);
      if (clk_status_i == clk_en_o) begin
        clk_delay = 0;
      end else if (clk_delay == 0) begin
        clk_delay = $urandom_range(1, 4);
      end else begin
        clk_delay--;
        if (clk_delay == 0) clk_status_i = clk_en_o;
      end
    end
  end

  // ack rises after a request, falls after the request drops
  initial begin
    rst_ack_i = 1'b0;
    ack_delay = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ack_i == pwr_rst_o.rst_sys_req) begin
        ack_delay = 0;
      end else if (ack_delay == 0) begin
        ack_delay = $urandom_range(1, 4);
      end else begin
        ack_delay--;
        if (ack_delay == 0) rst_ack_i = pwr_rst_o.rst_sys_req;
      end
    end
  end

  // heartbeat every 16 cycles, well inside the timeout
  initial begin
    esc_ping_i = 1'b0;
    ping_cnt   = 0;
    forever begin
      @(negedge clk_i);
      ping_cnt   = (ping_cnt + 1) % 16;
      esc_ping_i = ping_en && (ping_cnt == 0);
    end
  end

  // compare each new reset request with the reference
  always @(negedge clk_i) begin
    if (!rst_caliptra_ss_lc_n || !pwr_rst_o.rst_sys_req) begin
      rst_seen = 1'b0;
    end else if (!rst_seen) begin
      rst_seen = 1'b1;
      check_rst("reset request", exp_rst, pwr_rst_o);
      check_cause("reset cause", exp_cause, reset_cause_o);
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic apply_reset();
    @(negedge clk_i);
    rst_caliptra_ss_lc_n = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_caliptra_ss_lc_n = 1'b1;
    cfg_model = '0;
  endtask

  // taken says whether the lock is expected open
  task automatic write_cfg(input pwrmgr_pkg::pwr_cfg_t c, input logic taken);
    cfg_i    = c;
    cfg_wr_i = 1'b1;
    @(negedge clk_i);
    cfg_wr_i = 1'b0;
    if (taken) cfg_model = c;
  endtask

  task automatic clear_status();
    intr_clr_i      = 1'b1;
    wake_info_clr_i = 1'b1;
    @(negedge clk_i);
    intr_clr_i      = 1'b0;
    wake_info_clr_i = 1'b0;
  endtask

  task automatic enter_low_power(input pwrmgr_pkg::pwr_cfg_t c);
    int cycles;
    write_cfg(c, 1'b1);
    wait_bit("lock to close", sig_regwen, 1'b0, 10, cycles);
    core_sleeping_i = 1'b1;
    wait_bit("low power entry", sig_low_power, 1'b1, 50, cycles);
  endtask

  task automatic leave_low_power();
    wakeups_i       = '0;
    core_sleeping_i = 1'b0;
    @(negedge clk_i);
  endtask

  // a line outside the model mask must not wake, one inside must
  task automatic wake_through_mask();
    int off_line;
    int on_line;
    int cycles;
    off_line = lowest_bit(cfg_model.wakeup_en, 1'b0);
    on_line  = lowest_bit(cfg_model.wakeup_en, 1'b1);
    wakeups_i[off_line] = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      check_bit("low power with disabled wakeup", 1'b1, low_power_o);
    end
    wakeups_i[on_line] = 1'b1;
    wait_bit("clock enable after wakeup", sig_clk_en, 1'b1, 50, cycles);
    wait_bit("lock after wakeup", sig_regwen, 1'b1, 50, cycles);
    check_wake_info("wake reasons", expected_wake(wakeups_i, cfg_model.wakeup_en, 1'b0, 1'b0),
                    wake_info_o);
  endtask

  task automatic run_reset_case(input logic [`PWR_NUM_RST_REQS-1:0] periph,
                                input logic ndm, input logic [3:0] sw);
    int cycles;
    exp_rst = expected_reset(periph, ndm, sw, 1'b0, cfg_model, exp_cause);
    clear_status();
    rstreqs_i      = periph;
    ndmreset_req_i = ndm;
    sw_rst_req_i   = sw;
    if (exp_rst.rst_sys_req) begin
      wait_bit("reset request", sig_sys_req, 1'b1, 10, cycles);
      // 2 sync stages then the fsm flop
      check_bit("reset latency of 3 cycles", 1'b1, cycles == 3);
      rstreqs_i      = '0;
      ndmreset_req_i = 1'b0;
      sw_rst_req_i   = 4'h0;
      wait_bit("wakeup interrupt after reset", sig_intr, 1'b1, 50, cycles);
    end else begin
      repeat (12) @(negedge clk_i);
      check_bit("no reset request", 1'b0, pwr_rst_o.rst_sys_req);
      rstreqs_i      = '0;
      ndmreset_req_i = 1'b0;
      sw_rst_req_i   = 4'h0;
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int                        cycles;
    pwrmgr_pkg::pwr_cfg_t      cfg;
    pwrmgr_pkg::pwr_wkup_vec_t en;
    pwrmgr_pkg::pwr_wkup_vec_t lines;
    logic [3:0]                sw;
    void'($urandom(32'hda8e_aeb8));
    rst_caliptra_ss_lc_n = 1'b0;
    cfg_wr_i        = 1'b0;
    cfg_i           = '0;
    intr_clr_i      = 1'b0;
    wake_info_clr_i = 1'b0;
    wakeups_i       = '0;
    rstreqs_i       = '0;
    sw_rst_req_i    = 4'h0;
    ndmreset_req_i  = 1'b0;
    esc_req_i       = 1'b0;
    core_sleeping_i = 1'b0;
    ping_en         = 1'b1;
    test_name       = "power_on";
    exp_rst         = '0;
    exp_cause       = '0;
    cfg_model       = '0;
    apply_reset();

    // full sleep and wake with interrupt
    test_name = "low_power_cycle";
    en    = 4'($urandom_range(1, 15));
    lines = 4'($urandom_range(1, 15));
    if ((lines & en) == '0) lines = lines | en;
    clear_status();
    enter_low_power(make_cfg(1'b1, en, '0, 1'b1));
    check_bit("interrupt while in low power", 1'b0, intr_wakeup_o);
    wakeups_i = lines;
    wait_bit("clock enable after wakeup", sig_clk_en, 1'b1, 50, cycles);
    wait_bit("wakeup interrupt", sig_intr, 1'b1, 50, cycles);
    check_bit("lock reopened", 1'b1, cfg_regwen_o);
    check_wake_info("wake reasons", expected_wake(lines, en, 1'b0, 1'b0), wake_info_o);
    leave_low_power();

    test_name = "disabled_wakeup";
    clear_status();
    enter_low_power(make_cfg(1'b1, 4'($urandom_range(1, 14)), '0, 1'b0));
    wake_through_mask();
    leave_low_power();

    // pending wakeup skips low power
    test_name = "fall_through";
    clear_status();
    cfg = make_cfg(1'b1, 4'hf, '0, 1'b0);
    write_cfg(cfg, 1'b1);
    wait_bit("lock to close", sig_regwen, 1'b0, 10, cycles);
    wakeups_i = 4'($urandom_range(1, 15));
    repeat (3) @(negedge clk_i);
    core_sleeping_i = 1'b1;
    cycles = 0;
    while (!cfg_regwen_o && cycles < 100) begin
      @(negedge clk_i);
      check_bit("low power on fall-through", 1'b0, low_power_o);
      cycles++;
    end
    if (!cfg_regwen_o) fail_stop("timeout in fall_through while waiting for the lock to reopen");
    check_wake_info("fall-through record", expected_wake('0, 4'hf, 1'b1, 1'b0), wake_info_o);
    leave_low_power();
    clear_status();
    check_wake_info("cleared record", '0, wake_info_o);

    // core wakes while clocks are going down
    test_name = "abort";
    write_cfg(cfg, 1'b1);
    wait_bit("lock to close", sig_regwen, 1'b0, 10, cycles);
    core_sleeping_i = 1'b1;
    wait_bit("clock enable to drop", sig_clk_en, 1'b0, 20, cycles);
    core_sleeping_i = 1'b0;
    wait_bit("lock to reopen", sig_regwen, 1'b1, 20, cycles);
    check_bit("low power on abort", 1'b0, low_power_o);
    check_wake_info("abort record", expected_wake('0, 4'hf, 1'b0, 1'b1), wake_info_o);
    clear_status();
    check_wake_info("cleared record", '0, wake_info_o);

    test_name = "reset_requests";
    for (int i = 0; i < 8; i++) begin
      write_cfg(make_cfg(1'b0, '0, 2'($urandom_range(0, 3)), 1'b1), 1'b1);
      sw = $urandom_range(0, 1) ? `PWR_MUBI4_TRUE : 4'($urandom_range(0, 15));
      run_reset_case(2'($urandom_range(0, 3)), 1'($urandom_range(0, 1)), sw);
    end
    // masked peripheral line
    write_cfg(make_cfg(1'b0, '0, 2'b01, 1'b1), 1'b1);
    run_reset_case(2'b10, 1'b0, 4'h0);
    // near miss on the sw code
    run_reset_case(2'b00, 1'b0, `PWR_MUBI4_TRUE ^ 4'hf);

    test_name = "escalation";
    exp_rst = expected_reset('0, 1'b0, 4'h0, 1'b1, cfg_model, exp_cause);
    esc_req_i = 1'b1;
    wait_bit("lc reset request", sig_lc_req, 1'b1, 10, cycles);
    check_rst("escalation request", exp_rst, pwr_rst_o);
    esc_req_i = 1'b0;
    ping_en   = 1'b0;
    apply_reset();

    // no heartbeat after reset
    test_name = "esc_timeout";
    wait_bit("escalation timeout", sig_esc_timeout, 1'b1, 200, cycles);
    check_bit("timeout not before the limit", 1'b1, cycles >= `PWR_ESC_TIMEOUT_CNT);
    wait_bit("lc reset request", sig_lc_req, 1'b1, 10, cycles);
    check_rst("timeout request", exp_rst, pwr_rst_o);
    ping_en = 1'b1;
    apply_reset();

    // dropped write must leave the old mask in place
    test_name = "locked_write";
    clear_status();
    en = 4'($urandom_range(1, 14));
    enter_low_power(make_cfg(1'b1, en, '0, 1'b1));
    write_cfg(make_cfg(1'b1, ~en, '0, 1'b1), 1'b0);
    check_bit("lock during write", 1'b0, cfg_regwen_o);
    wake_through_mask();
    leave_low_power();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
pwrmgr_pkg.sv
pwrmgr_req_capture.sv
pwrmgr_esc_monitor.sv
pwrmgr_fsm.sv
pwrmgr_wake_info.sv
pwrmgr_cfg_regs.sv
pwrmgr_top.sv
tb_pwrmgr.sv

// ==== Makefile ====
# Verilator build and run for the power manager testbench

VERILATOR ?= verilator
TOP       ?= tb_pwrmgr
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
